/* common/rv_core_pkg.sv */
// RV core shared definitions
package rv_core_pkg;

  //////////////////////////////////////////////////
  // widths and fetch addresses
  //////////////////////////////////////////////////
  localparam int XLEN       = 32;                  // data and address width
  localparam int REG_ADDR_W = 5;                   // x0..x31
  localparam int OPC_W      = 7;                   // major opcode field
  localparam int F3_W       = 3;                   // funct3 field
  localparam int ALU_OP_W   = 4;                   // alu operation code

  localparam logic [XLEN-1:0] PC_RESET = 32'h0000_0000; // first fetch address
  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;         // one word per instruction

  // fetch fsm states
  localparam logic ST_IDLE = 1'b0;                 // bus idle, one cycle between requests
  localparam logic ST_REQ  = 1'b1;                 // cyc/stb high, waiting on ack

  //////////////////////////////////////////////////
  // opcodes and funct3
  //////////////////////////////////////////////////
  localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011; // register-register
  localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011; // register-immediate

  localparam logic [F3_W-1:0] F3_ADD  = 3'b000;    // add / sub
  localparam logic [F3_W-1:0] F3_SLL  = 3'b001;
  localparam logic [F3_W-1:0] F3_SLT  = 3'b010;
  localparam logic [F3_W-1:0] F3_SLTU = 3'b011;
  localparam logic [F3_W-1:0] F3_XOR  = 3'b100;
  localparam logic [F3_W-1:0] F3_SR   = 3'b101;    // srl / sra
  localparam logic [F3_W-1:0] F3_OR   = 3'b110;
  localparam logic [F3_W-1:0] F3_AND  = 3'b111;

  // alu operation codes
  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

  //////////////////////////////////////////////////
  // instruction word, R and I views
  //////////////////////////////////////////////////
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;               // bit 5 picks sub / sra
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [F3_W-1:0]       funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [OPC_W-1:0]      opcode;
    } r;
    struct packed {
      logic [11:0]           imm12;                // signed, shamt in [4:0]
      logic [REG_ADDR_W-1:0] rs1;
      logic [F3_W-1:0]       funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [OPC_W-1:0]      opcode;
    } i;
  } instr_u;

endpackage

/* dv/rv_core_chk.sv */
// Bus and retire assertions
`timescale 1ns/10ps

module rv_core_chk (
  input logic                               i_clk,
  input logic                               i_arst_n,
  input logic                               o_wb_cyc,
  input logic                               o_wb_stb,
  input logic [rv_core_pkg::XLEN-1:0]       o_wb_adr,
  input logic                               i_wb_ack,
  input logic                               o_rd_we,
  input logic [rv_core_pkg::REG_ADDR_W-1:0] o_rd_addr
);
  int fails = 0;                                       // read by the testbench

  //////////////////////////////////////////////////
  // wishbone classic rules
  //////////////////////////////////////////////////
  a_stb_cyc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_wb_stb |-> o_wb_cyc) else begin
    fails++;
    $error("stb high without cyc");
  end

  a_adr_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_wb_stb && !i_wb_ack) |=> $stable(o_wb_adr)) else begin
    fails++;
    $error("fetch address moved before ack");
  end

  // retire port never names x0
  a_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_rd_we |-> (o_rd_addr != '0)) else begin
    fails++;
    $error("retire with rd equal to x0");
  end

  a_reset_idle: assert property (@(posedge i_clk) !i_arst_n |-> !o_wb_cyc) else begin
    fails++;
    $error("cyc high during reset");
  end

endmodule

bind rv_core rv_core_chk u_rv_core_chk (.*);

/* dv/rv_core_tb.sv */
// RV core testbench
`timescale 1ns/10ps

module rv_core_tb;
  import rv_core_pkg::*;

  localparam int N_OP        = 200;                    // register-register
  localparam int N_IMM       = 200;                    // register-immediate
  localparam int N_FWD       = 200;                    // x1..x3 only
  localparam int N_DISC      = 100;                    // x0 targets, bad opcodes
  localparam int TOTAL       = N_OP + N_IMM + N_FWD + N_DISC;
  localparam int CYCLE_LIMIT = TOTAL * 6 + 50;         // 5 cycles worst case per fetch
  localparam logic [31:0] LFSR_SEED = 32'h384dbfda;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;    // x^32+x^22+x^2+x+1

  logic                  i_clk;
  logic                  i_arst_n;
  logic                  o_wb_cyc;
  logic                  o_wb_stb;
  logic [XLEN-1:0]       o_wb_adr;
  logic                  i_wb_ack;
  logic [XLEN-1:0]       i_wb_dat;
  logic                  o_rd_we;
  logic [REG_ADDR_W-1:0] o_rd_addr;
  logic [XLEN-1:0]       o_rd_data;

  logic [31:0]     lfsr_q;
  logic [XLEN-1:0] mregs [0:31];                       // reference register file
  instr_u          fetch_q [$];                        // requested, not yet retired
  instr_u          cur_word;                           // word of the open request
  logic            pending;                            // request built, ack not yet given
  int              wait_cnt;                           // idle cycles before ack
  int              cycles;
  int              acked;
  int              issued;
  int              target;                             // instructions allowed so far
  int              cur_mode;                           // 1 op, 2 op-imm, 3 fwd, 4 discard
  int              errors;
  int              tests_failed;

  rv_core u_rv_core (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .o_wb_cyc  (o_wb_cyc),
    .o_wb_stb  (o_wb_stb),
    .o_wb_adr  (o_wb_adr),
    .i_wb_ack  (i_wb_ack),
    .i_wb_dat  (i_wb_dat),
    .o_rd_we   (o_rd_we),
    .o_rd_addr (o_rd_addr),
    .o_rd_data (o_rd_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  //////////////////////////////////////////////////
  // random numbers and instruction builder
  //////////////////////////////////////////////////
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v      = {v[30:0], lfsr_q[0]};                   // one step per bit
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic logic [4:0] low_reg();
    return 5'(rand_bits(2) % 3 + 1);                   // x1, x2 or x3
  endfunction

  function automatic instr_u build_instr(input int mode);
    instr_u     w;
    logic [2:0] f3;
    logic       alt;
    logic       imm_op;
    w      = rand_bits(32);
    f3     = rand_bits(3);
    alt    = rand_bits(1);
    imm_op = (mode == 2) ? 1'b1 : (mode == 1) ? 1'b0 : rand_bits(1);
    if (mode == 3) begin
      w.r.rs1 = low_reg();
      w.r.rs2 = low_reg();
      w.r.rd  = low_reg();
    end
    w.r.funct3 = f3;
    w.r.opcode = imm_op ? OPC_OP_IMM : OPC_OP;
    if (!imm_op) begin
      w.r.funct7 = {1'b0, alt && (f3 == F3_ADD || f3 == F3_SR), 5'b0}; // sub, sra
    end else if (f3 == F3_SLL || f3 == F3_SR) begin
      w.i.imm12[11:5] = {1'b0, alt && (f3 == F3_SR), 5'b0};            // srai
    end
    if (mode == 4) begin
      case (rand_bits(2))
        0: begin
          w.r.opcode = rand_bits(7);                   // anything but op / op-imm
          if (w.r.opcode == OPC_OP || w.r.opcode == OPC_OP_IMM) begin
            w.r.opcode = w.r.opcode ^ 7'h10;
          end
        end
        1:       w.r.rd  = '0;                         // write to x0 is dropped
        default: w.r.rs1 = '0;                         // reads x0
      endcase
    end
    return w;
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic logic writes_reg(input instr_u w);
    return ((w.r.opcode == OPC_OP) || (w.r.opcode == OPC_OP_IMM)) && (w.r.rd != '0);
  endfunction

  function automatic logic [XLEN-1:0] model_result(input instr_u w);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] r;
    logic [4:0]      sh;
    logic            alt;
    a   = mregs[w.r.rs1];
    b   = (w.r.opcode == OPC_OP) ? mregs[w.r.rs2] : {{20{w.i.imm12[11]}}, w.i.imm12};
    sh  = b[4:0];
    alt = w.r.funct7[5];
    case (w.r.funct3)
      F3_ADD:  r = (w.r.opcode == OPC_OP && alt) ? a - b : a + b;
      F3_SLL:  r = a << sh;
      F3_SLT:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b}; // sign decides first
      F3_SLTU: r = {31'b0, a < b};
      F3_XOR:  r = a ^ b;
      F3_SR:   r = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
      F3_OR:   r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // memory model, retire check and cycle limit, all on the falling edge
  always @(negedge i_clk) begin : bus_and_retire
    instr_u          w;
    logic            found;
    logic [XLEN-1:0] exp_val;
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end else begin
      if (o_rd_we) begin
        found = 1'b0;
        while (!found && fetch_q.size() > 0) begin
          w     = fetch_q.pop_front();                 // non-writers are skipped
          found = writes_reg(w);
        end
        assert (found) else begin
          $display("Retire of x%0d at %0t with no writing instruction pending", o_rd_addr, $time);
          errors++;
        end
        if (found) begin
          exp_val        = model_result(w);
          mregs[w.r.rd]  = exp_val;
          assert (o_rd_addr == w.r.rd && o_rd_data == exp_val) else begin
            $display("Error at %0t: retire x%0d = %h, expected x%0d = %h",
                     $time, o_rd_addr, o_rd_data, w.r.rd, exp_val);
            errors++;
          end
        end
      end
      i_wb_ack = 1'b0;
      if (i_arst_n && o_wb_cyc && o_wb_stb) begin
        if (!pending && issued < target) begin
          assert (o_wb_adr == PC_RESET + PC_STEP * XLEN'(acked)) else begin
            $display("Error at %0t: fetch address %h, expected %h",
                     $time, o_wb_adr, PC_RESET + PC_STEP * XLEN'(acked));
            errors++;
          end
          cur_word = build_instr(cur_mode);
          fetch_q.push_back(cur_word);
          issued++;
          pending  = 1'b1;
          wait_cnt = rand_bits(2);                     // 0..3 idle cycles
        end
        if (pending) begin
          if (wait_cnt == 0) begin
            i_wb_ack = 1'b1;
            i_wb_dat = cur_word;
            pending  = 1'b0;
            acked++;
          end else begin
            wait_cnt--;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  task automatic run_test(input string name, input int mode, input int n);
    int     err_start;
    int     chk_start;
    int     err_now;
    instr_u w;
    err_start = errors;
    chk_start = u_rv_core.u_rv_core_chk.fails;
    cur_mode  = mode;
    target    = target + n;
    wait (acked == target);
    repeat (3) @(posedge i_clk);                       // last one commits
    while (fetch_q.size() > 0) begin
      w = fetch_q.pop_front();
      assert (!writes_reg(w)) else begin
        $display("Write to x%0d was fetched but never retired", w.r.rd);
        errors++;
      end
    end
    err_now = (errors - err_start) + (u_rv_core.u_rv_core_chk.fails - chk_start);
    if (err_now != 0) begin
      tests_failed++;
    end
    $display("test %-18s %0d instructions, %0d errors", name, n, err_now);
  endtask

  initial begin : main
    int chk_fails;
    i_arst_n = 1'b0;
    i_wb_ack = 1'b0;
    i_wb_dat = '0;
    lfsr_q   = LFSR_SEED;
    pending  = 1'b0;
    for (int k = 0; k < 32; k++) begin
      mregs[k] = '0;
    end
    repeat (3) @(negedge i_clk);
    i_arst_n = 1'b1;
    run_test("register-register", 1, N_OP);
    run_test("register-immediate", 2, N_IMM);
    run_test("forwarding", 3, N_FWD);
    run_test("discarded writes", 4, N_DISC);
    chk_fails = u_rv_core.u_rv_core_chk.fails;
    $display("tests 4, failed %0d, check errors %0d, assertion failures %0d",
             tests_failed, errors, chk_fails);
    if (errors == 0 && chk_fails == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* exec/rv_decode.sv */
// OP / OP-IMM decoder
`timescale 1ns/10ps

module rv_decode (
  input  rv_core_pkg::instr_u                i_instr,       // captured word
  input  logic                               i_instr_valid, // word is new this cycle
  output logic [rv_core_pkg::ALU_OP_W-1:0]   o_alu_op,
  output logic                               o_use_imm,     // operand b from o_imm
  output logic [rv_core_pkg::XLEN-1:0]       o_imm,         // sign-extended imm12 or shamt
  output logic [rv_core_pkg::REG_ADDR_W-1:0] o_rd_addr,
  output logic                               o_rd_we
);
  import rv_core_pkg::*;

  logic            is_op;                              // register-register
  logic            is_op_imm;                          // register-immediate
  logic            alt;                                // funct7[5]
  logic [F3_W-1:0] f3;

  assign is_op     = (i_instr.r.opcode == OPC_OP);
  assign is_op_imm = (i_instr.i.opcode == OPC_OP_IMM);
  assign alt       = i_instr.r.funct7[5];              // same bit as imm12[10]
  assign f3        = i_instr.r.funct3;

  //////////////////////////////////////////////////
  // alu operation select
  //////////////////////////////////////////////////
  always_comb begin
    case (f3)
      F3_ADD:  o_alu_op = (is_op && alt) ? ALU_SUB : ALU_ADD; // no subi
      F3_SLL:  o_alu_op = ALU_SLL;
      F3_SLT:  o_alu_op = ALU_SLT;
      F3_SLTU: o_alu_op = ALU_SLTU;
      F3_XOR:  o_alu_op = ALU_XOR;
      F3_SR:   o_alu_op = alt ? ALU_SRA : ALU_SRL;    // both opcodes
      F3_OR:   o_alu_op = ALU_OR;
      F3_AND:  o_alu_op = ALU_AND;
      default: o_alu_op = ALU_ADD;
    endcase
  end

  // immediate, shifts keep only shamt
  always_comb begin
    if ((f3 == F3_SLL) || (f3 == F3_SR)) begin
      o_imm = {{(XLEN-5){1'b0}}, i_instr.i.imm12[4:0]};
    end else begin
      o_imm = {{(XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};
    end
  end

  assign o_use_imm = is_op_imm;
  assign o_rd_addr = i_instr.i.rd;                     // same place in both views

  // unsupported opcodes and x0 retire silently
  assign o_rd_we = i_instr_valid && (is_op || is_op_imm) && (i_instr.i.rd != '0);

endmodule

/* exec/rv_execute.sv */
// ALU and commit register
`timescale 1ns/10ps

module rv_execute (
  input  logic                               i_clk,
  input  logic                               i_arst_n,
  input  logic [rv_core_pkg::ALU_OP_W-1:0]   i_alu_op,
  input  logic                               i_use_imm,   // b = imm instead of rs2
  input  logic [rv_core_pkg::XLEN-1:0]       i_imm,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_rd_addr,
  input  logic                               i_rd_we,     // valid, supported, rd != 0
  input  logic [rv_core_pkg::XLEN-1:0]       i_rs1_data,
  input  logic [rv_core_pkg::XLEN-1:0]       i_rs2_data,
  output logic                               o_rd_we,     // retire strobe
  output logic [rv_core_pkg::REG_ADDR_W-1:0] o_rd_addr,
  output logic [rv_core_pkg::XLEN-1:0]       o_rd_data
);
  import rv_core_pkg::*;

  logic [XLEN-1:0]       op_a;
  logic [XLEN-1:0]       op_b;
  logic [4:0]            shamt;                        // low five bits of b
  logic [XLEN-1:0]       result;
  logic                  we_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic [XLEN-1:0]       data_q;

  assign op_a  = i_rs1_data;
  assign op_b  = i_use_imm ? i_imm : i_rs2_data;
  assign shamt = op_b[4:0];

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////
  always_comb begin
    case (i_alu_op)
      ALU_ADD:  result = op_a + op_b;
      ALU_SUB:  result = op_a - op_b;
      ALU_SLL:  result = op_a << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  result = op_a ^ op_b;
      ALU_SRL:  result = op_a >> shamt;
      ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt); // sign fill
      ALU_OR:   result = op_a | op_b;
      ALU_AND:  result = op_a & op_b;
      default:  result = op_a + op_b;
    endcase
  end

  //////////////////////////////////////////////////
  // commit register
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      we_q   <= 1'b0;
      rd_q   <= '0;
      data_q <= '0;
    end else begin
      we_q <= i_rd_we;                                 // single-cycle strobe
      if (i_rd_we) begin
        rd_q   <= i_rd_addr;                           // hold last retire otherwise
        data_q <= result;
      end
    end
  end

  // same register drives retire port and rf write port
  assign o_rd_we   = we_q;
  assign o_rd_addr = rd_q;
  assign o_rd_data = data_q;

endmodule

/* exec/rv_operand_read.sv */
// Register file with commit forwarding
`timescale 1ns/10ps

module rv_operand_read (
  input  logic                               i_clk,
  input  logic                               i_arst_n,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_rs1_addr,
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_rs2_addr,
  input  logic                               i_wr_en,     // commit register valid
  input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_wr_addr,   // commit rd
  input  logic [rv_core_pkg::XLEN-1:0]       i_wr_data,   // commit result
  output logic [rv_core_pkg::XLEN-1:0]       o_rs1_data,
  output logic [rv_core_pkg::XLEN-1:0]       o_rs2_data
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] regs_q [1:31];                      // x0 is not stored

  //////////////////////////////////////////////////
  // write port, fed by the commit register
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int k = 1; k < 32; k++) begin
        regs_q[k] <= '0;                               // all registers start at zero
      end
    end else if (i_wr_en && (i_wr_addr != '0)) begin
      regs_q[i_wr_addr] <= i_wr_data;
    end
  end

  // one read port, x0 first, then forward, then array
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
    logic [XLEN-1:0] val;
    if (addr == '0) begin
      val = '0;                                        // x0 hardwired
    end else if (i_wr_en && (i_wr_addr == addr)) begin
      val = i_wr_data;                                 // addr non-zero, so rd is too
    end else begin
      val = regs_q[addr];
    end
    return val;
  endfunction

  //////////////////////////////////////////////////
  // read ports
  //////////////////////////////////////////////////
  always_comb begin
    o_rs1_data = read_port(i_rs1_addr);
    o_rs2_data = read_port(i_rs2_addr);
  end

endmodule

/* rtl/rv_core.sv */
// RV32I integer core top
`timescale 1ns/10ps

module rv_core (
  input  logic                               i_clk,
  input  logic                               i_arst_n,
  output logic                               o_wb_cyc,    // instruction bus
  output logic                               o_wb_stb,
  output logic [rv_core_pkg::XLEN-1:0]       o_wb_adr,
  input  logic                               i_wb_ack,
  input  logic [rv_core_pkg::XLEN-1:0]       i_wb_dat,
  output logic                               o_rd_we,     // retire trace
  output logic [rv_core_pkg::REG_ADDR_W-1:0] o_rd_addr,
  output logic [rv_core_pkg::XLEN-1:0]       o_rd_data
);
  import rv_core_pkg::*;

  instr_u                fetch_instr;                  // instruction register
  logic                  fetch_valid;
  logic [ALU_OP_W-1:0]   dec_alu_op;
  logic                  dec_use_imm;
  logic [XLEN-1:0]       dec_imm;
  logic [REG_ADDR_W-1:0] dec_rd_addr;
  logic                  dec_rd_we;
  logic [XLEN-1:0]       rs1_data;                     // forwarded operands
  logic [XLEN-1:0]       rs2_data;

  //////////////////////////////////////////////////
  // stage 1, fetch
  //////////////////////////////////////////////////
  rv_fetch u_fetch (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .o_wb_cyc      (o_wb_cyc),
    .o_wb_stb      (o_wb_stb),
    .o_wb_adr      (o_wb_adr),
    .i_wb_ack      (i_wb_ack),
    .i_wb_dat      (i_wb_dat),
    .o_instr       (fetch_instr),
    .o_instr_valid (fetch_valid)
  );

  // stage 2, decode and operand read side by side
  rv_decode u_decode (
    .i_instr       (fetch_instr),
    .i_instr_valid (fetch_valid),
    .o_alu_op      (dec_alu_op),
    .o_use_imm     (dec_use_imm),
    .o_imm         (dec_imm),
    .o_rd_addr     (dec_rd_addr),
    .o_rd_we       (dec_rd_we)
  );

  rv_operand_read u_operand_read (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_rs1_addr    (fetch_instr.r.rs1),                // fields straight from the ir
    .i_rs2_addr    (fetch_instr.r.rs2),
    .i_wr_en       (o_rd_we),                          // commit register loops back
    .i_wr_addr     (o_rd_addr),
    .i_wr_data     (o_rd_data),
    .o_rs1_data    (rs1_data),
    .o_rs2_data    (rs2_data)
  );

  // stage 3, execute and commit
  rv_execute u_execute (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_alu_op      (dec_alu_op),
    .i_use_imm     (dec_use_imm),
    .i_imm         (dec_imm),
    .i_rd_addr     (dec_rd_addr),
    .i_rd_we       (dec_rd_we),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .o_rd_we       (o_rd_we),
    .o_rd_addr     (o_rd_addr),
    .o_rd_data     (o_rd_data)
  );

endmodule

/* rtl/rv_fetch.sv */
// Wishbone instruction fetch
`timescale 1ns/10ps

module rv_fetch (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  output logic                         o_wb_cyc,       // bus cycle active
  output logic                         o_wb_stb,       // read request
  output logic [rv_core_pkg::XLEN-1:0] o_wb_adr,       // fetch address
  input  logic                         i_wb_ack,       // word on i_wb_dat is valid
  input  logic [rv_core_pkg::XLEN-1:0] i_wb_dat,       // instruction word
  output rv_core_pkg::instr_u          o_instr,        // instruction register
  output logic                         o_instr_valid   // one pulse per captured word
);
  import rv_core_pkg::*;

  logic            state_q;                            // ST_IDLE / ST_REQ
  logic [XLEN-1:0] pc_q;                               // address of current fetch
  logic            valid_q;                            // high in cycle after ack
  instr_u          ir_q;                               // captured word
  logic            take;                               // ack seen on open request

  assign take = (state_q == ST_REQ) && i_wb_ack;

  //////////////////////////////////////////////////
  // bus master fsm
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= ST_IDLE;                              // bus quiet in reset
      pc_q    <= PC_RESET;
      valid_q <= 1'b0;
    end else begin
      valid_q <= take;                                 // pulse follows the ack edge
      case (state_q)
        ST_IDLE: state_q <= ST_REQ;                    // open the next request
        ST_REQ: begin
          if (i_wb_ack) begin
            state_q <= ST_IDLE;                        // cyc/stb drop for one cycle
            pc_q    <= pc_q + PC_STEP;                 // straight-line code only
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // instruction register, loaded on ack
  always_ff @(posedge i_clk) begin
    if (take) begin
      ir_q <= i_wb_dat;
    end
  end

  assign o_wb_cyc      = (state_q == ST_REQ);
  assign o_wb_stb      = (state_q == ST_REQ);          // classic cycle, stb tracks cyc
  assign o_wb_adr      = pc_q;                         // stable until ack
  assign o_instr       = ir_q;
  assign o_instr_valid = valid_q;

endmodule

/* rv_core.f */
common/rv_core_pkg.sv
rtl/rv_fetch.sv
exec/rv_decode.sv
exec/rv_operand_read.sv
exec/rv_execute.sv
rtl/rv_core.sv
dv/rv_core_chk.sv
dv/rv_core_tb.sv
